// File: design/microPkg.sv
package microPkg;

    // control word and state widths
    localparam int ctrlWordWidth = 45;
    localparam int stateWidth    = 7;

    // states 0 to 20 are in use
    localparam int numStates = 21;

    // sequencing field sits in the top bits of the control word
    localparam int seqFieldWidth = 2;

    // instruction opcodes, INSTR bits 2:0
    typedef enum logic [2:0] {
        opAdd    = 3'd0,
        opSub    = 3'd1,
        opAnd    = 3'd2,
        opOr     = 3'd3,
        opLoad   = 3'd4,
        opStore  = 3'd5,
        opBranch = 3'd6,
        opHalt   = 3'd7
    } opcodeT;

    // sequencing ops, control word bits 44:43
    typedef enum logic [seqFieldWidth-1:0] {
        seqNext     = 2'd0,
        seqDispatch = 2'd1,
        seqBranch   = 2'd2,
        seqEnd      = 2'd3
    } seqOpT;

    // APB register map
    typedef enum logic [3:0] {
        addrCtrl   = 4'h0,
        addrInstr  = 4'h4,
        addrStatus = 4'h8,
        addrSteps  = 4'hC
    } regAddrT;

    // fixed states of the common prologue
    localparam logic [stateWidth-1:0] stateIdle   = 7'd0;
    localparam logic [stateWidth-1:0] stateFetch  = 7'd1;
    localparam logic [stateWidth-1:0] stateDecode = 7'd3;

endpackage

// File: design/microStore.sv
`timescale 1ns/100ps

module microStore (
    input  logic                               reset,
    input  logic [microPkg::stateWidth-1:0]    currentState,
    output logic [microPkg::ctrlWordWidth-1:0] controlWord
);
    import microPkg::*;

    // idle word, also driven in reset and for unused states
    localparam logic [ctrlWordWidth-1:0] idleWord =
        45'b001001100000000000000000000001000000000100001;

    seqOpT                    seqOp;
    logic [ctrlWordWidth-1:0] dataBits;

    // sequencing op per state
    always_comb begin
        case (currentState)
            // decode picks the routine
            stateDecode: seqOp = seqDispatch;
            // branch routine, flag decides
            7'd15: seqOp = seqBranch;
            // last state of every routine
            7'd5, 7'd7, 7'd8, 7'd9, 7'd12, 7'd14, 7'd16, 7'd20: begin
                seqOp = seqEnd;
            end
            // fetch, routine bodies, idle and unused states
            default: seqOp = seqNext;
        endcase
        if (reset) begin
            seqOp = seqNext;
        end
    end

    // datapath patterns, top two bits are replaced below
    always_comb begin
        case (currentState)
            stateIdle: dataBits = idleWord;
            // fetch
            7'd1: dataBits = 45'b011000000000100000000000000000000000000100011;
            7'd2: dataBits = 45'b000000000000010001100011000000000000000100011;
            // decode
            7'd3: dataBits = 45'b000000000000001100100011000000000000000100011;
            // add
            7'd4: dataBits = 45'b100000000000001100100011000000000001000100111;
            7'd5: dataBits = 45'b000000000000000000000000000000000000000100000;
            // sub
            7'd6: dataBits = 45'b000110100001000000000000000000000000000100001;
            7'd7: dataBits = 45'b000010101010000010000000000000000000000100011;
            // and, or
            7'd8: dataBits = 45'b000011000101000001000000000000000000000100011;
            7'd9: dataBits = 45'b000000000100000100000000000000000000000100011;
            // load
            7'd10: dataBits = 45'b000000000100000100000000000000000010010100101;
            7'd11: dataBits = 45'b000010100001000000000000000111100000000101110;
            7'd12: dataBits = 45'b001001000000000000000000001000100000100100010;
            // store
            7'd13: dataBits = 45'b000011000101000001000000000000000000000100011;
            7'd14: dataBits = 45'b000000000100001100000000000000000000000100011;
            // branch, taken path continues to 16
            7'd15: dataBits = 45'b000000000100001110000000000000000011110100111;
            7'd16: dataBits = 45'b000110010010000000000000000000000000000100001;
            // halt
            7'd17: dataBits = 45'b000110100001000000000000000000100000000100001;
            7'd18: dataBits = 45'b000111010001000000000000000000000000000100001;
            7'd19: dataBits = 45'b000110100001000000000000000111000000000100001;
            7'd20: dataBits = 45'b000111010001000000000000000111000000000100001;
            // anything else behaves like idle
            default: dataBits = idleWord;
        endcase
        if (reset) begin
            dataBits = idleWord;
        end
    end

    // sequencing op on top, datapath bits below
    assign controlWord = {seqOp, dataBits[ctrlWordWidth-seqFieldWidth-1:0]};

endmodule

// File: design/microSequencer.sv
`timescale 1ns/100ps

module microSequencer #(
    parameter int stepWidth = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  microPkg::opcodeT                   opcode,
    input  logic                               flag,
    input  logic [microPkg::ctrlWordWidth-1:0] controlWord,
    output logic [microPkg::stateWidth-1:0]    currentState,
    output logic                               busy,
    output logic                               done,
    output logic                               halted,
    output logic [stepWidth-1:0]               stepCount
);
    import microPkg::*;

    seqOpT                 seqOp;
    opcodeT                runOpcode;
    logic                  runFlag;
    logic [stateWidth-1:0] nextState;
    logic                  endNow;
    logic                  accept;
    logic [stepWidth-1:0]  stepCounter;

    // entry state of each routine
    function automatic logic [stateWidth-1:0] entryState(opcodeT op);
        case (op)
            opAdd:    entryState = stateWidth'(4);
            opSub:    entryState = stateWidth'(6);
            opAnd:    entryState = stateWidth'(8);
            opOr:     entryState = stateWidth'(9);
            opLoad:   entryState = stateWidth'(10);
            opStore:  entryState = stateWidth'(13);
            opBranch: entryState = stateWidth'(15);
            default:  entryState = stateWidth'(17);
        endcase
    endfunction

    // only the sequencing field matters here
    assign seqOp = seqOpT'(controlWord[ctrlWordWidth-1 -: seqFieldWidth]);

    // anything outside idle is an instruction in flight
    assign busy   = (currentState != stateIdle);
    assign accept = !busy && start;

    always_comb begin
        nextState = currentState;
        endNow    = 1'b0;
        if (!busy) begin
            // idle word says next, but wait for start
            if (start) begin
                nextState = stateFetch;
            end
        end else begin
            case (seqOp)
                seqNext: nextState = currentState + 1'b1;
                seqDispatch: nextState = entryState(runOpcode);
                seqBranch: begin
                    // not taken ends the routine here
                    if (runFlag) begin
                        nextState = currentState + 1'b1;
                    end else begin
                        nextState = stateIdle;
                        endNow    = 1'b1;
                    end
                end
                default: begin
                    nextState = stateIdle;
                    endNow    = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            currentState <= stateIdle;
            runOpcode    <= opAdd;
            runFlag      <= 1'b0;
            stepCounter  <= '0;
            stepCount    <= '0;
            done         <= 1'b0;
            halted       <= 1'b0;
        end else begin
            currentState <= nextState;
            // one cycle pulse after the last state
            done         <= endNow;
            if (accept) begin
                // hold instruction for the whole run
                runOpcode   <= opcode;
                runFlag     <= flag;
                stepCounter <= stepWidth'(1);
            end else if (busy && !endNow) begin
                stepCounter <= stepCounter + 1'b1;
            end
            if (endNow) begin
                // counter already includes the last state
                stepCount <= stepCounter;
                if (runOpcode == opHalt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/microRegs.sv
`timescale 1ns/100ps

module microRegs #(
    parameter int stepWidth = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [3:0]                      paddr,
    input  logic [31:0]                     pwdata,
    input  logic                            busy,
    input  logic                            done,
    input  logic                            halted,
    input  logic [stepWidth-1:0]            stepCount,
    input  logic [microPkg::stateWidth-1:0] currentState,
    output logic [31:0]                     prdata,
    output logic                            start,
    output microPkg::opcodeT                opcode,
    output logic                            flag
);
    import microPkg::*;

    // active state position in STATUS
    localparam int statusStateLsb = 8;

    logic access;
    logic writeEn;
    logic readEn;
    logic startReq;
    logic doneFlag;
    logic doneBit;

    // zero wait states, access phase completes the transfer
    assign access  = psel && penable;
    assign writeEn = access && pwrite;
    assign readEn  = access && !pwrite;

    // start request from CTRL bit 0
    assign startReq = writeEn && (paddr == addrCtrl) && pwdata[0];

    // dropped while running or after halt
    assign start = startReq && !busy && !halted;

    // INSTR register, opcode and branch flag
    always_ff @(posedge clk) begin
        if (reset) begin
            opcode <= opAdd;
            flag   <= 1'b0;
        end else if (writeEn && (paddr == addrInstr)) begin
            opcode <= opcodeT'(pwdata[2:0]);
            flag   <= pwdata[3];
        end
    end

    // sticky done, an accepted start wins over the pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            doneFlag <= 1'b0;
        end else if (start) begin
            doneFlag <= 1'b0;
        end else if (done) begin
            doneFlag <= 1'b1;
        end
    end

    // pulse shows up in the same cycle as STEPS
    assign doneBit = doneFlag || done;

    // read mux, zero outside the access phase
    always_comb begin
        prdata = '0;
        if (readEn) begin
            case (paddr)
                addrInstr: begin
                    prdata[3:0] = {flag, opcode};
                end
                addrStatus: begin
                    prdata[0] = busy;
                    prdata[1] = doneBit;
                    prdata[2] = halted;
                    prdata[statusStateLsb +: stateWidth] = currentState;
                end
                addrSteps: begin
                    // step count of the last finished instruction
                    prdata[stepWidth-1:0] = stepCount;
                end
                // CTRL is write only
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

// File: design/microController.sv
`timescale 1ns/100ps

module microController #(
    parameter int stepWidth = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [3:0]                         paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic [microPkg::ctrlWordWidth-1:0] controlWord,
    output logic [microPkg::stateWidth-1:0]    activeState
);
    import microPkg::*;

    // regs to sequencer
    logic                 start;
    opcodeT               opcode;
    logic                 flag;
    // sequencer status back to regs
    logic                 busy;
    logic                 done;
    logic                 halted;
    logic [stepWidth-1:0] stepCount;

    // host side register block
    microRegs #(.stepWidth(stepWidth)) regs0 (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .busy(busy),
        .done(done),
        .halted(halted),
        .stepCount(stepCount),
        .currentState(activeState),
        .prdata(prdata),
        .start(start),
        .opcode(opcode),
        .flag(flag)
    );

    // control state goes straight out as activeState
    microSequencer #(.stepWidth(stepWidth)) seq0 (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opcode(opcode),
        .flag(flag),
        .controlWord(controlWord),
        .currentState(activeState),
        .busy(busy),
        .done(done),
        .halted(halted),
        .stepCount(stepCount)
    );

    // microprogram lookup
    microStore store0 (
        .reset(reset),
        .currentState(activeState),
        .controlWord(controlWord)
    );

endmodule

// File: dv/microControllerProps.sv
`timescale 1ns/100ps

module microControllerProps (
    input logic                            clk,
    input logic                            reset,
    input logic                            start,
    input logic                            busy,
    input logic                            done,
    input logic [microPkg::stateWidth-1:0] currentState
);
    import microPkg::*;

    // idle stays in state 0 until a start arrives
    idleHold: assert property (@(posedge clk) disable iff (reset)
        (!busy && !start) |=> (currentState == stateIdle))
        else $error("sequencer left state 0 without a start");

    // done is a single cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // only states 0 to 20 exist in the microstore
    stateRange: assert property (@(posedge clk) disable iff (reset)
        32'(currentState) < numStates)
        else $error("control state outside the microprogram");

endmodule

// attach to the sequencer inside the top level
bind microSequencer microControllerProps props0 (
    .clk(clk),
    .reset(reset),
    .start(start),
    .busy(busy),
    .done(done),
    .currentState(currentState)
);

// File: dv/microControllerTb.sv
`timescale 1ns/100ps

module microControllerTb;
    import microPkg::*;

    localparam int stepWidth   = 8;
    localparam int clkPeriod   = 20;
    localparam int driveDelay  = 2;
    localparam int resetCycles = 10;
    localparam int numRandom   = 200;
    // 300 instruction slots of 12 cycles, plus reset and margin
    localparam int timeoutCycles = 300 * 12 + 200;

    logic                     clk;
    logic                     reset;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [3:0]               paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic [ctrlWordWidth-1:0] controlWord;
    logic [stateWidth-1:0]    activeState;

    int          seed;
    int          cycleCount = 0;
    int          trace[$];
    logic [31:0] readData;
    logic [2:0]  opBits;
    logic        flagBit;
    logic        pokeBit;

    microController #(.stepWidth(stepWidth)) dut0 (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .controlWord(controlWord),
        .activeState(activeState)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // hard stop in case a handshake never shows up
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not finish within %0d clock cycles", timeoutCycles);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // next edge, then the drive offset
    task automatic tick();
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // setup phase, access phase, write lands on the second edge
    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        tick();
        penable = 1'b1;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // read data is combinational in the access phase
    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        tick();
        penable = 1'b1;
        #5;
        data = prdata;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // first state of each routine, from the microprogram listing
    function automatic int routineEntry(opcodeT op);
        case (op)
            opAdd:    return 4;
            opSub:    return 6;
            opAnd:    return 8;
            opOr:     return 9;
            opLoad:   return 10;
            opStore:  return 13;
            opBranch: return 15;
            default:  return 17;
        endcase
    endfunction

    // routine length, branch grows by one when taken
    function automatic int routineLength(opcodeT op, logic flag);
        case (op)
            opAdd, opSub, opStore: return 2;
            opAnd, opOr:           return 1;
            opLoad:                return 3;
            opBranch:              return flag ? 2 : 1;
            default:               return 4;
        endcase
    endfunction

    // fetch 1 and 2, decode 3, then the routine
    task automatic buildTrace(input opcodeT op, input logic flag);
        int entry;
        int len;
        entry = routineEntry(op);
        len   = routineLength(op, flag);
        trace.delete();
        trace.push_back(1);
        trace.push_back(2);
        trace.push_back(3);
        for (int i = 0; i < len; i++) begin
            trace.push_back(entry + i);
        end
    endtask

    task automatic runInstr(input opcodeT op, input logic flag, input logic pokeStart);
        int          n;
        logic [31:0] data;
        logic [31:0] expStatus;
        logic [31:0] expRunning;
        seqOpT       expSeq;
        buildTrace(op, flag);
        n = trace.size();
        expStatus = (op == opHalt) ? 32'h6 : 32'h2;
        // busy set, done cleared by the start, state 3 in bits 14:8
        expRunning = (32'd3 << 8) | 32'h1;
        apbWrite(addrInstr, {28'd0, flag, op});
        apbWrite(addrCtrl, 32'd1);
        // state 1 is already up after the start edge
        for (int i = 0; i < n; i++) begin
            if (i > 0) begin
                tick();
            end
            checkValue(64'(activeState), 64'(trace[i]), "activeState off the trace");
            // decode dispatches, state 15 branches, a routine's last state ends
            expSeq = seqNext;
            if (trace[i] == 3) begin
                expSeq = seqDispatch;
            end else if (trace[i] == 15) begin
                expSeq = seqBranch;
            end else if (i == n - 1) begin
                expSeq = seqEnd;
            end
            checkValue(64'(controlWord[ctrlWordWidth-1 -: 2]), 64'(expSeq),
                       "sequencing field");
            // access phase lands while decode runs
            // either an extra start or a STATUS read
            if (i == 1) begin
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = pokeStart;
                paddr   = pokeStart ? addrCtrl : addrStatus;
                pwdata  = 32'd1;
            end else if (i == 2) begin
                penable = 1'b1;
                if (!pokeStart) begin
                    #5;
                    checkValue(64'(prdata), 64'(expRunning), "STATUS while running");
                end
            end else if (i == 3) begin
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
            end
        end
        tick();
        checkValue(64'(activeState), 64'd0, "state after routine end");
        apbRead(addrStatus, data);
        checkValue(64'(data), 64'(expStatus), "STATUS after instruction");
        apbRead(addrSteps, data);
        checkValue(64'(data), 64'(n), "STEPS after instruction");
        apbRead(addrInstr, data);
        checkValue(64'(data), 64'({28'd0, flag, op}), "INSTR readback");
        // no second instruction sneaked in
        checkValue(64'(activeState), 64'd0, "state after readback");
    endtask

    initial begin
        seed    = 32'h8164_ea29;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'd0;
        pwdata  = 32'd0;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        reset = 1'b0;

        // post reset state
        checkValue(64'(activeState), 64'd0, "activeState after reset");
        checkValue(64'(controlWord[ctrlWordWidth-1 -: 2]), 64'(seqNext),
                   "sequencing field after reset");
        apbRead(addrStatus, readData);
        checkValue(64'(readData), 64'd0, "STATUS after reset");
        apbRead(addrSteps, readData);
        checkValue(64'(readData), 64'd0, "STEPS after reset");

        // branch both ways, then a late start
        runInstr(opBranch, 1'b0, 1'b0);
        runInstr(opBranch, 1'b1, 1'b0);
        runInstr(opLoad, 1'b0, 1'b1);

        // random mix, halt kept out
        for (int k = 0; k < numRandom; k++) begin
            opBits  = 3'({$random(seed)} % 7);
            flagBit = 1'($random(seed));
            pokeBit = 1'($random(seed));
            runInstr(opcodeT'(opBits), flagBit, pokeBit);
        end

        runInstr(opHalt, 1'b0, 1'b1);

        // halted ignores every start
        for (int k = 0; k < 3; k++) begin
            apbWrite(addrInstr, 32'(k));
            apbWrite(addrCtrl, 32'd1);
            checkValue(64'(activeState), 64'd0, "state after start while halted");
            tick();
            checkValue(64'(activeState), 64'd0, "state one cycle later");
            apbRead(addrStatus, readData);
            checkValue(64'(readData), 64'h6, "STATUS while halted");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: microController.f
design/microPkg.sv
design/microStore.sv
design/microSequencer.sv
design/microRegs.sv
design/microController.sv
dv/microControllerProps.sv
dv/microControllerTb.sv

// File: Makefile
VERILATOR := verilator
TOP       := microControllerTb
RTLTOP    := microController
FILELIST  := microController.f
BUILDDIR  := obj_dir
LOG       := sim.log
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
